//--- Makefile
VERILATOR ?= verilator
TOP       ?= armCore_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@if grep -q "^ALL TESTS PASSED$$" $(LOG); then \
	  echo "Simulation passed"; else echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/alu.sv
// Add, subtract, AND and OR with NZCV generation
`timescale 1ns/10ps
`include "arm_cfg.svh"

module alu import armPkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  aluOp_e op,
  output word_t  result,
  output flags_t flags
);

  localparam int MSB = `ARM_XLEN - 1;

  logic              sub;
  logic              arith;
  word_t             bInv;
  logic [`ARM_XLEN:0] sum;  // Extra bit holds the carry-out

  assign sub   = (op == ALU_SUB);
  assign arith = (op == ALU_ADD) | sub;
  assign bInv  = sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, bInv} + {{`ARM_XLEN{1'b0}}, sub};

  always_comb begin
    case (op)
      ALU_AND: result = a & b;
      ALU_ORR: result = a | b;
      default: result = sum[MSB:0];
    endcase
  end

  assign flags.n = result[MSB];
  assign flags.z = (result == '0);
  assign flags.c = arith & sum[`ARM_XLEN];
  // Same operand signs but the sum flips sign
  assign flags.v = arith & (a[MSB] == bInv[MSB]) & (sum[MSB] != a[MSB]);
endmodule

//--- hdl/armCore.sv
// Single-cycle ARM subset core, top level for the instruction and data memories
`timescale 1ns/10ps

module armCore import armPkg::*; (
  input  logic  clk,
  input  logic  reset,
  output word_t pc,
  input  word_t instr,
  output logic  memWrite,
  output word_t aluResult,
  output word_t writeData,
  input  word_t readData,
  input  logic  pcReady
);

  ctrlIf bus ();

  controller ctrl (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .pcReady  (pcReady),
    .memWrite (memWrite),
    .bus      (bus.ctrl)
  );

  datapath dp (
    .clk       (clk),
    .reset     (reset),
    .pcReady   (pcReady),
    .bus       (bus.dp),
    .instr     (instr),
    .readData  (readData),
    .pc        (pc),
    .aluResult (aluResult),
    .writeData (writeData)
  );

endmodule

//--- hdl/armPkg.sv
// Shared types for the single-cycle ARM core, imported by the RTL and the testbench
`include "arm_cfg.svh"

package armPkg;

  typedef logic [`ARM_XLEN-1:0] word_t;  // Data, address or instruction
  typedef logic [3:0] regAddr_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef enum logic [1:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR
  } aluOp_e;

  // Immediate field kinds, IMM24 is the branch offset
  typedef enum logic [1:0] {
    IMM8, IMM12, IMM24
  } immSrc_e;

  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL
  } cond_e;

endpackage

//--- hdl/arm_cfg.svh
// Core-wide sizing constants, included by the package and the RTL that needs them
`ifndef ARM_CFG_SVH
`define ARM_CFG_SVH

// Data and address width
`define ARM_XLEN 32

// Architectural register count
`define ARM_NREGS 16

// R15 doubles as the PC
`define ARM_PCREG 15

// Byte step between instructions
`define ARM_PCSTEP 4

`endif

//--- hdl/condUnit.sv
// Flag registers and condition check that gate every architectural write
`timescale 1ns/10ps

module condUnit import armPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  cond_e      cond,
  input  flags_t     aluFlags,
  input  logic [1:0] flagWriteReq,
  input  logic       regWriteReq,
  input  logic       memWriteReq,
  input  logic       pcWriteReq,
  input  logic       pcReady,
  output logic       regWrite,
  output logic       memWrite,
  output logic       pcSrc
);

  flags_t     flags;
  logic       condEx;
  logic       retire;
  logic [1:0] flagWrite;

  // Nothing retires during a stall or while held in reset
  assign retire    = pcReady & ~reset;
  assign flagWrite = flagWriteReq & {2{condEx & retire}};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) {flags.n, flags.z} <= 2'b00;
    else if (flagWrite[1]) {flags.n, flags.z} <= {aluFlags.n, aluFlags.z};
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) {flags.c, flags.v} <= 2'b00;
    else if (flagWrite[0]) {flags.c, flags.v} <= {aluFlags.c, aluFlags.v};
  end

  always_comb begin
    case (cond)
      EQ: condEx = flags.z;
      NE: condEx = ~flags.z;
      CS: condEx = flags.c;
      CC: condEx = ~flags.c;
      MI: condEx = flags.n;
      PL: condEx = ~flags.n;
      VS: condEx = flags.v;
      VC: condEx = ~flags.v;
      HI: condEx = flags.c & ~flags.z;
      LS: condEx = ~flags.c | flags.z;
      GE: condEx = (flags.n == flags.v);
      LT: condEx = (flags.n != flags.v);
      GT: condEx = ~flags.z & (flags.n == flags.v);
      LE: condEx = flags.z | (flags.n != flags.v);
      AL: condEx = 1'b1;
      default: condEx = 1'b0;  // Code 1111 never executes
    endcase
  end

  assign regWrite = regWriteReq & condEx & retire;
  assign memWrite = memWriteReq & condEx & retire;
  assign pcSrc    = pcWriteReq & condEx;  // PC load itself waits on pcReady
endmodule

//--- hdl/controller.sv
// Instruction decoder, drives the control bundle and the store request
`timescale 1ns/10ps
`include "arm_cfg.svh"

module controller import armPkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t instr,
  input  logic  pcReady,
  output logic  memWrite,
  ctrlIf.ctrl   bus
);

  localparam logic [3:0] CMD_AND = 4'b0000;
  localparam logic [3:0] CMD_SUB = 4'b0010;
  localparam logic [3:0] CMD_ADD = 4'b0100;
  localparam logic [3:0] CMD_ORR = 4'b1100;

  logic [1:0] op;
  logic [5:0] funct;
  logic       isDp;
  logic       isArith;
  logic       branch;
  logic       regWriteReq;
  logic       memWriteReq;
  logic       pcWriteReq;
  logic [1:0] flagWriteReq;

  assign op    = instr[27:26];
  assign funct = instr[25:20];
  assign isDp  = (op == 2'b00);

  // Main decode
  always_comb begin
    bus.immSrc   = IMM8;
    bus.aluSrc   = 1'b0;
    bus.memToReg = 1'b0;
    bus.raSrcPc  = 1'b0;
    bus.raSrcRd  = 1'b0;
    regWriteReq  = 1'b0;
    memWriteReq  = 1'b0;
    branch       = 1'b0;
    case (op)
      2'b00: begin
        bus.aluSrc  = funct[5];  // I bit
        regWriteReq = 1'b1;
      end
      2'b01: begin
        bus.immSrc   = IMM12;
        bus.aluSrc   = 1'b1;
        bus.memToReg = funct[0];
        bus.raSrcRd  = ~funct[0];  // STR reads rd as store data
        regWriteReq  = funct[0];
        memWriteReq  = ~funct[0];
      end
      2'b10: begin
        bus.immSrc  = IMM24;
        bus.aluSrc  = 1'b1;
        bus.raSrcPc = 1'b1;  // Target is PC+8 plus offset
        branch      = 1'b1;
      end
      default: ;  // Unused op, no side effects
    endcase
  end

  // ALU decode, loads, stores and branches add
  always_comb begin
    bus.aluOp = ALU_ADD;
    if (isDp) begin
      case (funct[4:1])
        CMD_SUB: bus.aluOp = ALU_SUB;
        CMD_AND: bus.aluOp = ALU_AND;
        CMD_ORR: bus.aluOp = ALU_ORR;
        default: bus.aluOp = ALU_ADD;
      endcase
    end
  end

  assign isArith = isDp & ((funct[4:1] == CMD_ADD) | (funct[4:1] == CMD_SUB));
  assign flagWriteReq = {isDp & funct[0], isArith & funct[0]};  // {NZ, CV}

  assign pcWriteReq = branch |
                      (regWriteReq & (instr[15:12] == regAddr_t'(`ARM_PCREG)));

  condUnit cu (
    .clk          (clk),
    .reset        (reset),
    .cond         (cond_e'(instr[31:28])),
    .aluFlags     (bus.aluFlags),
    .flagWriteReq (flagWriteReq),
    .regWriteReq  (regWriteReq),
    .memWriteReq  (memWriteReq),
    .pcWriteReq   (pcWriteReq),
    .pcReady      (pcReady),
    .regWrite     (bus.regWrite),
    .memWrite     (memWrite),
    .pcSrc        (bus.pcSrc)
  );

endmodule

//--- hdl/ctrlIf.sv
// Control bundle and ALU flags passed between the controller and the datapath
`timescale 1ns/10ps

interface ctrlIf import armPkg::*; ();

  aluOp_e  aluOp;
  immSrc_e immSrc;
  logic    aluSrc;    // Immediate as operand B
  logic    memToReg;  // Load data to write-back
  logic    regWrite;
  logic    pcSrc;     // Next PC from result
  logic    raSrcPc;   // First read port on R15
  logic    raSrcRd;   // Second read port on rd
  flags_t  aluFlags;

  modport ctrl (output aluOp, immSrc, aluSrc, memToReg, regWrite, pcSrc,
                       raSrcPc, raSrcRd,
                input  aluFlags);

  modport dp (input  aluOp, immSrc, aluSrc, memToReg, regWrite, pcSrc,
                     raSrcPc, raSrcRd,
              output aluFlags);

endinterface

//--- hdl/datapath.sv
// PC, operand selection and write-back around the register file and ALU
`timescale 1ns/10ps
`include "arm_cfg.svh"

module datapath import armPkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  pcReady,
  ctrlIf.dp     bus,
  input  word_t instr,
  input  word_t readData,
  output word_t pc,
  output word_t aluResult,
  output word_t writeData
);

  word_t    pcNext;
  word_t    pcPlus4;
  word_t    pcPlus8;
  word_t    extImm;
  word_t    srcA;
  word_t    srcB;
  word_t    result;
  regAddr_t ra1;
  regAddr_t ra2;

  assign pcPlus4 = pc + word_t'(`ARM_PCSTEP);
  assign pcPlus8 = pcPlus4 + word_t'(`ARM_PCSTEP);
  assign pcNext  = bus.pcSrc ? result : pcPlus4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) pc <= '0;
    else if (pcReady) pc <= pcNext;
  end

  assign ra1 = bus.raSrcPc ? regAddr_t'(`ARM_PCREG) : instr[19:16];  // rn
  assign ra2 = bus.raSrcRd ? instr[15:12] : instr[3:0];              // rd or rm

  regFile rf (
    .clk (clk),
    .we  (bus.regWrite),
    .ra1 (ra1),
    .ra2 (ra2),
    .wa  (instr[15:12]),
    .wd  (result),
    .r15 (pcPlus8),
    .rd1 (srcA),
    .rd2 (writeData)
  );

  always_comb begin
    case (bus.immSrc)
      IMM8:    extImm = {24'b0, instr[7:0]};
      IMM12:   extImm = {20'b0, instr[11:0]};
      IMM24:   extImm = {{6{instr[23]}}, instr[23:0], 2'b00};  // Word offset
      default: extImm = '0;
    endcase
  end

  assign srcB = bus.aluSrc ? extImm : writeData;

  alu alu (
    .a      (srcA),
    .b      (srcB),
    .op     (bus.aluOp),
    .result (aluResult),
    .flags  (bus.aluFlags)
  );

  assign result = bus.memToReg ? readData : aluResult;
endmodule

//--- hdl/regFile.sv
// Register file with two combinational reads and one clocked write, R15 from outside
`timescale 1ns/10ps
`include "arm_cfg.svh"

module regFile import armPkg::*; (
  input  logic     clk,
  input  logic     we,
  input  regAddr_t ra1,
  input  regAddr_t ra2,
  input  regAddr_t wa,
  input  word_t    wd,
  input  word_t    r15,
  output word_t    rd1,
  output word_t    rd2
);

  word_t rf [0:`ARM_NREGS-2];  // R0 to R14 only

  // A write to R15 lands in the PC instead
  always_ff @(posedge clk) begin
    if (we && wa != regAddr_t'(`ARM_PCREG)) rf[wa] <= wd;
  end

  assign rd1 = (ra1 == regAddr_t'(`ARM_PCREG)) ? r15 : rf[ra1];
  assign rd2 = (ra2 == regAddr_t'(`ARM_PCREG)) ? r15 : rf[ra2];
endmodule

//--- tb/armCore_asserts.sv
// Port-level checks on the core, bound to every armCore instance
`timescale 1ns/10ps

module armCore_asserts import armPkg::*; (
  input logic  clk,
  input logic  reset,
  input word_t pc,
  input logic  memWrite,
  input logic  pcReady
);

  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // A stalled instruction must not store
  noStoreInStall: assert property (@(posedge clk) disable iff (reset) !pcReady |-> !memWrite)
    else $error("memWrite high while pcReady is low");

  pcHoldsInStall: assert property (@(posedge clk) disable iff (reset)
    !pcReady |=> $stable(pc))
    else $error("pc moved during a stall");

endmodule

bind armCore armCore_asserts asserts (
  .clk      (clk),
  .reset    (reset),
  .pc       (pc),
  .memWrite (memWrite),
  .pcReady  (pcReady)
);

//--- tb/armCore_tb.sv
// Testbench for armCore that runs the program from the vectors file and checks every store
`timescale 1ns/10ps

module armCore_tb import armPkg::*; ();

  logic  clk = 1'b0;
  logic  reset;
  logic  pcReady;
  logic  memWrite;
  word_t pc;
  word_t instr;
  word_t aluResult;
  word_t writeData;
  word_t readData;

  word_t       vec [0:127];  // Header, program image, then store pairs
  word_t       mem [0:255];  // Unified instruction and data memory
  word_t       budget;
  int          progLen;
  int          pairLen;
  int          storeIdx;
  logic        seenFirst;
  logic [31:0] lfsr;

  armCore uut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .instr     (instr),
    .memWrite  (memWrite),
    .aluResult (aluResult),
    .writeData (writeData),
    .readData  (readData),
    .pcReady   (pcReady)
  );

  assign instr    = mem[pc[9:2]];
  assign readData = mem[aluResult[9:2]];

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    lfsrNext = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      abortRun("value mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
      abortRun("control bit mismatch");
    end
  endtask

  initial begin
    forever #5 clk = ~clk;
  end

  initial begin
    logic b0;
    reset     = 1'b1;
    pcReady   = 1'b1;
    lfsr      = 32'h284a;
    storeIdx  = 0;
    seenFirst = 1'b0;
    $readmemh("tb/armCore_vectors.txt", vec);
    budget  = vec[0];
    progLen = int'(vec[1]);
    pairLen = int'(vec[2]);
    for (int i = 0; i < 256; i++) mem[i] = ~(word_t'(i) << 2);  // Address-dependent fill
    for (int i = 0; i < progLen; i++) mem[i] = vec[3 + i];
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    // Random stalls with ready three cycles out of four
    while (storeIdx < pairLen) begin
      @(posedge clk);
      #1;
      lfsr    = lfsrNext(lfsr);
      b0      = lfsr[0];
      lfsr    = lfsrNext(lfsr);
      pcReady = b0 | lfsr[0];
    end
    // Core should now spin on its branch-to-self without storing
    repeat (20) begin
      @(posedge clk);
      #1 pcReady = 1'b1;
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Outputs settle by mid-cycle where the stores are checked
  always @(negedge clk) begin
    if (reset) begin
      checkWord("pc", pc, '0);
      checkBit("memWrite", memWrite, 1'b0);
    end else begin
      if (!seenFirst) begin
        checkWord("pc", pc, '0);  // First fetch after reset
        seenFirst <= 1'b1;
      end
      if (!pcReady) checkBit("memWrite", memWrite, 1'b0);
      if (memWrite) begin
        if (storeIdx >= pairLen) begin
          abortRun("store seen after the last expected store");
        end else begin
          checkWord("aluResult", aluResult, vec[3 + progLen + 2 * storeIdx]);
          checkWord("writeData", writeData, vec[4 + progLen + 2 * storeIdx]);
          storeIdx <= storeIdx + 1;
        end
      end
    end
  end

  // Data memory write at the retiring edge
  always @(posedge clk) begin
    if (memWrite) mem[aluResult[9:2]] <= writeData;
  end

  // Four times the cycle budget before giving up
  initial begin
    @(negedge reset);
    #(budget * 40);
    abortRun("timeout: the program did not finish its stores");
  end

endmodule

//--- tb/armCore_vectors.txt
// Header: cycle budget, program word count, store pair count (hex)
// Then program words from address 0, then expected stores as address data pairs
64 3A 1A
E04F000F E2801005 E2412002 E0013002 // 00 R0=0 R1=5 R2=3 R3=1
E1814002 E080500F E5801200 E5802204 // 10 R4=7 R5=pc+8, stores
E5803208 E580420C E5805210 E5907204 // 20 stores, LDR R7
E5807214 E0518001 05801220 15801224 // 30 STR R7, SUBS gives Z C
25801228 3580122C 45801230 55801234 // 40 conditional stores of R1
65801238 7580123C 85801240 95801244 // 50
A5801248 B580124C C5801250 D5801254 // 60
E5801258 E59090E4 E099A009 E011B002 // 70 LDR literal, ADDS gives Z C V, ANDS
05802260 15802264 25802268 3580226C // 80 conditional stores of R2
45802270 55802274 65802278 7580227C // 90
85802280 95802284 A5802288 B580228C // A0
C5802290 D5802294 E5802298 EA000000 // B0 B over next store
E5801300 E280C003 E580C304 E25CC001 // C0 loop of three
1AFFFFFC E28FF000 E5801300 E5804308 // D0 BNE, ADD into R15 skips a store
EAFFFFFE 80000000                   // E0 branch to self, literal
00000200 00000005 00000204 00000003
00000208 00000001 0000020C 00000007
00000210 0000001C 00000214 00000003
00000220 00000005 00000228 00000005
00000234 00000005 0000023C 00000005
00000244 00000005 00000248 00000005
00000254 00000005 00000258 00000005
00000264 00000003 00000268 00000003
00000274 00000003 00000278 00000003
00000280 00000003 0000028C 00000003
00000294 00000003 00000298 00000003
00000304 00000003 00000304 00000002
00000304 00000001 00000308 00000007

//--- verilog.f
+incdir+hdl
hdl/armPkg.sv
hdl/ctrlIf.sv
hdl/alu.sv
hdl/regFile.sv
hdl/condUnit.sv
hdl/controller.sv
hdl/datapath.sv
hdl/armCore.sv
tb/armCore_asserts.sv
tb/armCore_tb.sv
